// File: hdl/rvPkg.sv
`default_nettype none

package rvPkg;

   localparam int xlen          = 64;
   localparam int bytesPerWord  = xlen / 8;
   localparam int regAddrBits   = 5;
   localparam int memBytes      = 256;
   localparam int memAddrBits   = 8;

   // Major opcodes of the supported RV64I subset.
   localparam logic [6:0] opRType = 7'b0110011;
   localparam logic [6:0] opImm   = 7'b0010011;
   localparam logic [6:0] opLoad  = 7'b0000011;
   localparam logic [6:0] opStore = 7'b0100011;

   // Function codes. Add also serves addi.
   localparam logic [2:0] f3Add = 3'b000;
   localparam logic [2:0] f3Sub = 3'b000;
   localparam logic [2:0] f3And = 3'b111;
   localparam logic [2:0] f3Or  = 3'b110;
   localparam logic [2:0] f3Ld  = 3'b011;  // Doubleword load.
   localparam logic [2:0] f3Sd  = 3'b011;  // Doubleword store.
   localparam logic [6:0] f7Add = 7'b0000000;
   localparam logic [6:0] f7Sub = 7'b0100000;
   localparam logic [6:0] f7And = 7'b0000000;
   localparam logic [6:0] f7Or  = 7'b0000000;

   typedef enum logic [1:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr
   } aluOp;

   // The same 32 bits read in the R, I and S layouts.
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } rFields;
      struct packed {
         logic [11:0] imm;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } iFields;
      struct packed {
         logic [6:0] immHi;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] immLo;
         logic [6:0] opcode;
      } sFields;
   } instrWord;

   typedef struct packed {
      aluOp            op;
      logic [xlen-1:0] operandA;
      logic [xlen-1:0] operandB;   // Register value or sign-extended immediate.
      logic [xlen-1:0] storeData;
      logic            memRead;
      logic            memWrite;
   } execCmd;

   typedef enum logic [1:0] {
      aluResult,
      loadResult,
      storeDone,
      noOp
   } retireKind;

   typedef struct packed {
      logic [regAddrBits-1:0] rd;
      retireKind              kind;
   } issueTag;

   typedef struct packed {
      logic                   enable;
      logic [regAddrBits-1:0] addr;
      logic [xlen-1:0]        data;
   } regWrite;

   typedef struct packed {
      logic [regAddrBits-1:0] rd;
      retireKind              kind;
      logic [xlen-1:0]        value;  // Written value, or the address for sd.
   } retireInfo;

endpackage

`default_nettype wire

// File: hdl/instrDecoder.sv
`default_nettype none

module instrDecoder (
   input  wire logic                          clk,
   input  wire logic                          reset,
   input  wire logic                          instrValid,
   input  wire rvPkg::instrWord               instr,
   input  wire logic [rvPkg::xlen-1:0]        rs1Data,
   input  wire logic [rvPkg::xlen-1:0]        rs2Data,
   input  wire logic                          execTake,
   output logic                               instrReady,
   output logic [rvPkg::regAddrBits-1:0]      rs1Addr,
   output logic [rvPkg::regAddrBits-1:0]      rs2Addr,
   output rvPkg::execCmd                      cmd,
   output logic                               issueFire,
   output logic                               execValid,
   output rvPkg::issueTag                     tag
);

   logic           busy;     // Execute slot holds an instruction.
   rvPkg::issueTag tagNext;
   logic [rvPkg::xlen-1:0] immI;
   logic [rvPkg::xlen-1:0] immS;

   // A new instruction waits until the previous one has retired, so its
   // register reads always see the retired write.
   assign instrReady = !busy;
   assign issueFire  = instrValid && instrReady;
   assign execValid  = busy;

   // The S layout keeps rs1 and rs2 in the same bit positions as R.
   assign rs1Addr = instr.rFields.rs1;
   assign rs2Addr = instr.rFields.rs2;

   assign immI = {{(rvPkg::xlen-12){instr.iFields.imm[11]}}, instr.iFields.imm};
   assign immS = {{(rvPkg::xlen-12){instr.sFields.immHi[6]}},
                  instr.sFields.immHi, instr.sFields.immLo};

   always_comb begin
      cmd.op        = rvPkg::aluAdd;  // Loads and stores add for the address.
      cmd.operandA  = rs1Data;
      cmd.operandB  = immI;
      cmd.storeData = rs2Data;
      cmd.memRead   = 1'b0;
      cmd.memWrite  = 1'b0;
      tagNext.rd    = '0;
      tagNext.kind  = rvPkg::noOp;
      case (instr.rFields.opcode)
         rvPkg::opRType: begin
            cmd.operandB = rs2Data;
            tagNext.rd   = instr.rFields.rd;
            tagNext.kind = rvPkg::aluResult;
            case ({instr.rFields.funct7, instr.rFields.funct3})
               {rvPkg::f7Add, rvPkg::f3Add}: cmd.op = rvPkg::aluAdd;
               {rvPkg::f7Sub, rvPkg::f3Sub}: cmd.op = rvPkg::aluSub;
               {rvPkg::f7And, rvPkg::f3And}: cmd.op = rvPkg::aluAnd;
               {rvPkg::f7Or,  rvPkg::f3Or}:  cmd.op = rvPkg::aluOr;
               default: begin
                  tagNext.rd   = '0;
                  tagNext.kind = rvPkg::noOp;
               end
            endcase
         end
         rvPkg::opImm: begin
            if (instr.iFields.funct3 == rvPkg::f3Add) begin
               tagNext.rd   = instr.iFields.rd;
               tagNext.kind = rvPkg::aluResult;
            end
         end
         rvPkg::opLoad: begin
            if (instr.iFields.funct3 == rvPkg::f3Ld) begin
               cmd.memRead  = 1'b1;
               tagNext.rd   = instr.iFields.rd;
               tagNext.kind = rvPkg::loadResult;
            end
         end
         rvPkg::opStore: begin
            cmd.operandB = immS;
            if (instr.sFields.funct3 == rvPkg::f3Sd) begin
               cmd.memWrite = 1'b1;
               tagNext.kind = rvPkg::storeDone;  // No destination register.
            end
         end
         default: ;  // Anything else retires as a no-op.
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
      end else if (issueFire) begin
         busy <= 1'b1;
      end else if (execTake) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issueFire) tag <= tagNext;
   end

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`default_nettype none

module registerFile (
   input  wire logic                          clk,
   input  wire logic                          reset,
   input  wire logic [rvPkg::regAddrBits-1:0] rs1Addr,
   input  wire logic [rvPkg::regAddrBits-1:0] rs2Addr,
   input  wire rvPkg::regWrite                regWr,
   output logic [rvPkg::xlen-1:0]             rs1Data,
   output logic [rvPkg::xlen-1:0]             rs2Data
);

   localparam int numRegs = 2 ** rvPkg::regAddrBits;

   logic [rvPkg::xlen-1:0] regs [numRegs];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (regWr.enable && regWr.addr != '0) begin
         regs[regWr.addr] <= regWr.data;  // x0 is never written.
      end
   end

   // Reads are combinational; x0 is forced to zero on both ports.
   assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
   assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

   // The retire stage may still request writes to x0.
   x0StaysZero: assert property (
      @(posedge clk) disable iff (reset) regs[0] == '0
   ) else $error("Register x0 holds a nonzero value.");

endmodule

`default_nettype wire

// File: hdl/aluUnit.sv
`default_nettype none

module aluUnit (
   input  wire logic                   clk,
   input  wire rvPkg::execCmd          cmd,
   input  wire logic                   issueFire,
   output logic [rvPkg::xlen-1:0]      aluResult
);

   logic [rvPkg::xlen-1:0] result;

   // For ld and sd the decoder selects add, which yields the address.
   always_comb begin
      case (cmd.op)
         rvPkg::aluAdd: result = cmd.operandA + cmd.operandB;
         rvPkg::aluSub: result = cmd.operandA - cmd.operandB;
         rvPkg::aluAnd: result = cmd.operandA & cmd.operandB;
         rvPkg::aluOr:  result = cmd.operandA | cmd.operandB;
         default:       result = '0;
      endcase
   end

   // Captured once at issue and held until the next instruction.
   always_ff @(posedge clk) begin
      if (issueFire) begin
         aluResult <= result;
      end
   end

endmodule

`default_nettype wire

// File: hdl/dataMemory.sv
`default_nettype none

module dataMemory (
   input  wire logic                   clk,
   input  wire rvPkg::execCmd          cmd,
   input  wire logic                   issueFire,
   output logic [rvPkg::xlen-1:0]      loadData
);

   logic [7:0]                    mem [rvPkg::memBytes];
   logic [rvPkg::xlen-1:0]        sum;
   logic [rvPkg::memAddrBits-1:0] addr;

   initial begin
      for (int i = 0; i < rvPkg::memBytes; i++) begin
         mem[i] = 8'h00;
      end
   end

   // Own adder, so the access happens in the same cycle as the ALU.
   assign sum  = cmd.operandA + cmd.operandB;
   assign addr = sum[rvPkg::memAddrBits-1:0];

   // Big-endian: the most significant byte sits at the lowest address.
   // The byte index is 8 bits wide, so an access past 255 wraps to 0.
   always_ff @(posedge clk) begin
      if (issueFire && cmd.memWrite) begin
         for (int i = 0; i < rvPkg::bytesPerWord; i++) begin
            mem[addr + rvPkg::memAddrBits'(i)] <=
               cmd.storeData[rvPkg::xlen-1-8*i -: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issueFire && cmd.memRead) begin
         for (int i = 0; i < rvPkg::bytesPerWord; i++) begin
            loadData[rvPkg::xlen-1-8*i -: 8] <= mem[addr + rvPkg::memAddrBits'(i)];
         end
      end
   end

   // The decoder only ever sets one of the two strobes.
   oneAccessKind: assert property (
      @(posedge clk) issueFire |-> !(cmd.memRead && cmd.memWrite)
   ) else $error("Load and store requested together.");

endmodule

`default_nettype wire

// File: hdl/retireStage.sv
`default_nettype none

module retireStage (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic                   execValid,
   input  wire rvPkg::issueTag         tag,
   input  wire logic [rvPkg::xlen-1:0] aluResult,
   input  wire logic [rvPkg::xlen-1:0] loadData,
   input  wire logic                   wbReady,
   output logic                        execTake,
   output rvPkg::regWrite              regWr,
   output logic                        wbValid,
   output rvPkg::retireInfo            wb
);

   logic                   full;   // Output register holds a record.
   logic [rvPkg::xlen-1:0] value;

   assign execTake = execValid && (!full || wbReady);
   assign wbValid  = full;

   // Stores report their address, which is the ALU result.
   always_comb begin
      case (tag.kind)
         rvPkg::loadResult: value = loadData;
         rvPkg::aluResult:  value = aluResult;
         rvPkg::storeDone:  value = aluResult;
         default:           value = '0;
      endcase
   end

   // The register file is written on the same edge that loads the record.
   assign regWr.enable = execTake &&
                         (tag.kind == rvPkg::aluResult || tag.kind == rvPkg::loadResult);
   assign regWr.addr   = tag.rd;
   assign regWr.data   = value;

   always_ff @(posedge clk) begin
      if (reset) begin
         full <= 1'b0;
      end else if (execTake) begin
         full <= 1'b1;
      end else if (wbReady) begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (execTake) begin
         wb.rd    <= tag.rd;
         wb.kind  <= tag.kind;
         wb.value <= value;
      end
   end

   wbHeldUnderStall: assert property (
      @(posedge clk) disable iff (reset) wbValid && !wbReady |=> $stable(wb)
   ) else $error("Retire record changed while stalled.");

endmodule

`default_nettype wire

// File: hdl/datapathTop.sv
`default_nettype none

module datapathTop (
   input  wire logic               clk,
   input  wire logic               reset,
   input  wire logic               instrValid,
   input  wire rvPkg::instrWord    instr,
   input  wire logic               wbReady,
   output logic                    instrReady,
   output logic                    wbValid,
   output rvPkg::retireInfo        wb
);

   logic [rvPkg::regAddrBits-1:0] rs1Addr;
   logic [rvPkg::regAddrBits-1:0] rs2Addr;
   logic [rvPkg::xlen-1:0]        rs1Data;
   logic [rvPkg::xlen-1:0]        rs2Data;
   rvPkg::execCmd                 cmd;
   logic                          issueFire;
   logic                          execValid;
   logic                          execTake;
   rvPkg::issueTag                tag;
   rvPkg::regWrite                regWr;
   logic [rvPkg::xlen-1:0]        aluResult;
   logic [rvPkg::xlen-1:0]        loadData;

   instrDecoder i_decoder (
      .clk, .reset, .instrValid, .instr, .rs1Data, .rs2Data, .execTake,
      .instrReady, .rs1Addr, .rs2Addr, .cmd, .issueFire, .execValid, .tag
   );

   registerFile i_regFile (
      .clk, .reset, .rs1Addr, .rs2Addr, .regWr, .rs1Data, .rs2Data
   );

   // ALU and memory see the same command and work side by side.
   aluUnit i_alu (
      .clk, .cmd, .issueFire, .aluResult
   );

   dataMemory i_mem (
      .clk, .cmd, .issueFire, .loadData
   );

   retireStage i_retire (
      .clk, .reset, .execValid, .tag, .aluResult, .loadData, .wbReady,
      .execTake, .regWr, .wbValid, .wb
   );

endmodule

`default_nettype wire

// File: sim/retireChecker.sv
`default_nettype none

module retireChecker (
   input  wire logic             clk,
   input  wire logic             reset,
   input  wire logic             instrValid,
   input  wire logic             instrReady,
   input  wire logic [31:0]      instr,
   input  wire logic             wbValid,
   input  wire logic             wbReady,
   input  wire rvPkg::retireInfo wb,
   output int                    errorCount,
   output int                    retireCount,
   output int                    pendingCount
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [rvPkg::xlen-1:0] refRegs [32];
   logic [7:0]             refMem [rvPkg::memBytes];
   rvPkg::retireInfo       expected [$];  // Records in issue order.

   // Memory powers up as zero and is not touched by reset.
   initial begin
      refMem = '{default: 8'h00};
   end

   // Big-endian doubleword, with the byte index wrapping at 256.
   function automatic logic [63:0] readDoubleword(input logic [63:0] addr);
      logic [63:0] value;
      logic [7:0]  idx;
      value = '0;
      for (int i = 0; i < 8; i++) begin
         idx   = addr[7:0] + 8'(i);
         value = {value[55:0], refMem[idx]};
      end
      return value;
   endfunction

   function automatic void writeDoubleword(input logic [63:0] addr, input logic [63:0] data);
      logic [7:0] idx;
      for (int i = 0; i < 8; i++) begin
         idx         = addr[7:0] + 8'(i);
         refMem[idx] = data[63-8*i -: 8];  // Most significant byte first.
      end
   endfunction

   // Executes one instruction on the model and returns its retire record.
   function automatic rvPkg::retireInfo predictRetire(input logic [31:0] w);
      logic [6:0]       opcode;
      logic [6:0]       funct7;
      logic [2:0]       funct3;
      logic [4:0]       rd;
      logic [63:0]      a;
      logic [63:0]      b;
      logic [63:0]      immI;
      logic [63:0]      immS;
      rvPkg::retireInfo r;
      opcode  = w[6:0];
      rd      = w[11:7];
      funct3  = w[14:12];
      funct7  = w[31:25];
      a       = refRegs[w[19:15]];
      b       = refRegs[w[24:20]];
      immI    = {{52{w[31]}}, w[31:20]};
      immS    = {{52{w[31]}}, w[31:25], w[11:7]};
      r.rd    = '0;
      r.kind  = rvPkg::noOp;
      r.value = '0;
      case (opcode)
         rvPkg::opRType: begin
            r.rd   = rd;
            r.kind = rvPkg::aluResult;
            if (funct7 == rvPkg::f7Add && funct3 == rvPkg::f3Add) r.value = a + b;
            else if (funct7 == rvPkg::f7Sub && funct3 == rvPkg::f3Sub) r.value = a - b;
            else if (funct7 == rvPkg::f7And && funct3 == rvPkg::f3And) r.value = a & b;
            else if (funct7 == rvPkg::f7Or && funct3 == rvPkg::f3Or) r.value = a | b;
            else begin
               r.rd   = '0;
               r.kind = rvPkg::noOp;  // Unsupported function bits.
            end
         end
         rvPkg::opImm: begin
            if (funct3 == rvPkg::f3Add) begin
               r.rd    = rd;
               r.kind  = rvPkg::aluResult;
               r.value = a + immI;
            end
         end
         rvPkg::opLoad: begin
            if (funct3 == rvPkg::f3Ld) begin
               r.rd    = rd;
               r.kind  = rvPkg::loadResult;
               r.value = readDoubleword(a + immI);
            end
         end
         rvPkg::opStore: begin
            if (funct3 == rvPkg::f3Sd) begin
               r.kind  = rvPkg::storeDone;
               r.value = a + immS;  // A store reports its address.
               writeDoubleword(a + immS, b);
            end
         end
         default: ;
      endcase
      if ((r.kind == rvPkg::aluResult || r.kind == rvPkg::loadResult) && rd != 0) begin
         refRegs[rd] = r.value;
      end
      return r;
   endfunction

   task automatic checkField(input string name, input logic [63:0] got,
                             input logic [63:0] want);
      if (got !== want) begin
         $display("Mismatch %s: got %h expected %h (record %0d)", name, got, want,
                  retireCount);
         errorCount++;
      end
   endtask

   always @(posedge clk) begin : compare
      rvPkg::retireInfo want;
      if (reset) begin
         refRegs = '{default: '0};
         expected.delete();
         errorCount  = 0;
         retireCount = 0;
      end else begin
         // Retire first, so a record issued on this edge is queued behind it.
         if (wbValid && wbReady) begin
            if (expected.size() == 0) begin
               $display("A retire record for rd %0d appeared with no instruction outstanding.",
                        wb.rd);
               errorCount++;
            end else begin
               want = expected.pop_front();
               checkField("wb.rd", 64'(wb.rd), 64'(want.rd));
               checkField("wb.kind", 64'(wb.kind), 64'(want.kind));
               checkField("wb.value", wb.value, want.value);
               retireCount++;
            end
         end
         if (instrValid && instrReady) begin
            expected.push_back(predictRetire(instr));
         end
      end
      pendingCount = expected.size();
   end

endmodule

`default_nettype wire

// File: sim/tbDatapath.sv
`default_nettype none

module tbDatapath;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int waitLimit   = 200;  // Cycles allowed for any single wait.
   localparam int randomCount = 320;

   logic             clk;
   logic             reset;
   logic             instrValid;
   rvPkg::instrWord  instr;
   logic             wbReady;
   logic             instrReady;
   logic             wbValid;
   rvPkg::retireInfo wb;

   int   seed        = 32'hed1f_9380;
   logic holdStall   = 1'b0;  // Keeps wbReady low.
   logic randomStall = 1'b0;
   int   timeouts;
   int   flowErrors;
   int   errorCount;
   int   retireCount;
   int   pendingCount;

   datapathTop i_dut (
      .clk, .reset, .instrValid, .instr, .wbReady, .instrReady, .wbValid, .wb
   );

   retireChecker i_checker (
      .clk(clk), .reset(reset), .instrValid(instrValid), .instrReady(instrReady),
      .instr(instr), .wbValid(wbValid), .wbReady(wbReady), .wb(wb),
      .errorCount(errorCount), .retireCount(retireCount), .pendingCount(pendingCount)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Back-pressure on the retire port.
   initial begin
      wbReady = 1'b1;
      forever begin
         @(negedge clk);
         if (holdStall) wbReady = 1'b0;
         else if (randomStall) wbReady = ($random(seed) & 3) != 0;
         else wbReady = 1'b1;
      end
   end

   function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, rvPkg::opRType};
   endfunction

   function automatic logic [31:0] encodeI(input int imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
      return {imm[11:0], rs1, f3, rd, opcode};
   endfunction

   function automatic logic [31:0] encodeS(input int imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], rvPkg::opStore};
   endfunction

   function automatic logic [4:0] randomReg();
      return 5'(1 + ($unsigned($random(seed)) % 7));
   endfunction

   function automatic logic [31:0] randomInstr();
      int         pick;
      int         imm;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      pick = $unsigned($random(seed)) % 16;
      imm  = $random(seed) % 32;
      rd   = randomReg();
      rs1  = randomReg();
      rs2  = randomReg();
      case (pick)
         0, 1:       return encodeR(rvPkg::f7Add, rs2, rs1, rvPkg::f3Add, rd);
         2:          return encodeR(rvPkg::f7Sub, rs2, rs1, rvPkg::f3Sub, rd);
         3:          return encodeR(rvPkg::f7And, rs2, rs1, rvPkg::f3And, rd);
         4:          return encodeR(rvPkg::f7Or, rs2, rs1, rvPkg::f3Or, rd);
         5, 6, 7:    return encodeI(imm, rs1, rvPkg::f3Add, rd, rvPkg::opImm);
         8, 9, 10:   return encodeI(imm, rs1, rvPkg::f3Ld, rd, rvPkg::opLoad);
         11, 12, 13: return encodeS(imm, rs2, rs1, rvPkg::f3Sd);
         14:         return encodeR(7'b0000001, rs2, rs1, rvPkg::f3Add, rd);
         default:    return encodeI(imm, rs1, 3'b000, rd, 7'b1111111);
      endcase
   endfunction

   // Called on a falling edge; returns on the falling edge after the transfer.
   task automatic sendInstr(input logic [31:0] word);
      int waited;
      waited     = 0;
      instr      = word;
      instrValid = 1'b1;
      while (!instrReady && waited < waitLimit) begin
         @(negedge clk);
         waited++;
      end
      if (!instrReady) begin
         $display("Timeout: instruction %h was not accepted within %0d cycles.",
                  word, waitLimit);
         timeouts++;
      end else begin
         @(negedge clk);
      end
      instrValid = 1'b0;
   endtask

   task automatic idleCycles(input int count);
      repeat (count) @(negedge clk);
   endtask

   task automatic waitForDrain();
      int waited;
      waited = 0;
      while (pendingCount != 0 && waited < waitLimit) begin
         @(negedge clk);
         waited++;
      end
      if (pendingCount != 0) begin
         $display("Timeout: %0d retire records were still outstanding after %0d cycles.",
                  pendingCount, waitLimit);
         timeouts++;
      end
   endtask

   initial begin
      instrValid = 1'b0;
      instr      = '0;
      reset      = 1'b1;
      timeouts   = 0;
      flowErrors = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // R-type results on operands built by addi.
      sendInstr(encodeI(100, 0, rvPkg::f3Add, 1, rvPkg::opImm));
      sendInstr(encodeI(-37, 0, rvPkg::f3Add, 2, rvPkg::opImm));
      sendInstr(encodeI(2047, 0, rvPkg::f3Add, 3, rvPkg::opImm));
      sendInstr(encodeR(rvPkg::f7Add, 2, 1, rvPkg::f3Add, 4));
      sendInstr(encodeR(rvPkg::f7Sub, 2, 1, rvPkg::f3Sub, 5));
      sendInstr(encodeR(rvPkg::f7And, 3, 1, rvPkg::f3And, 6));
      sendInstr(encodeR(rvPkg::f7Or, 3, 2, rvPkg::f3Or, 7));
      sendInstr(encodeI(5, 1, rvPkg::f3Add, 0, rvPkg::opImm));  // Retires, x0 stays zero.
      sendInstr(encodeR(rvPkg::f7Or, 2, 1, rvPkg::f3Or, 0));
      sendInstr(encodeR(rvPkg::f7Add, 0, 1, rvPkg::f3Add, 8));
      sendInstr(encodeR(rvPkg::f7Add, 0, 0, rvPkg::f3Add, 9));

      // Store, reload, then every unaligned offset across two stored words.
      sendInstr(encodeR(rvPkg::f7Sub, 5, 0, rvPkg::f3Sub, 10));
      sendInstr(encodeS(16, 10, 0, rvPkg::f3Sd));
      sendInstr(encodeS(24, 3, 0, rvPkg::f3Sd));
      sendInstr(encodeI(16, 0, rvPkg::f3Ld, 11, rvPkg::opLoad));
      for (int off = 1; off < 8; off++) begin
         sendInstr(encodeI(16 + off, 0, rvPkg::f3Ld, 12, rvPkg::opLoad));
      end
      sendInstr(encodeI(128, 0, rvPkg::f3Ld, 13, rvPkg::opLoad));  // Never written.

      // Eight bytes from 252 wrap around to address 3.
      sendInstr(encodeS(252, 10, 0, rvPkg::f3Sd));
      sendInstr(encodeI(252, 0, rvPkg::f3Ld, 14, rvPkg::opLoad));
      sendInstr(encodeI(0, 0, rvPkg::f3Ld, 15, rvPkg::opLoad));
      sendInstr(encodeI(-4, 0, rvPkg::f3Ld, 16, rvPkg::opLoad));
      waitForDrain();

      // Fill retire and execute while the retire port is stalled.
      holdStall = 1'b1;
      idleCycles(2);
      sendInstr(encodeI(1, 1, rvPkg::f3Add, 1, rvPkg::opImm));
      sendInstr(encodeR(rvPkg::f7Add, 1, 1, rvPkg::f3Add, 2));
      idleCycles(5);
      if (!wbValid || instrReady) begin
         $display("Back-pressure failed to hold the pipeline: wbValid=%b instrReady=%b.",
                  wbValid, instrReady);
         flowErrors++;
      end
      fork
         sendInstr(encodeS(40, 2, 0, rvPkg::f3Sd));
         begin
            idleCycles(8);
            holdStall = 1'b0;
         end
      join
      sendInstr(encodeI(40, 0, rvPkg::f3Ld, 3, rvPkg::opLoad));
      waitForDrain();

      // Mixed traffic with gaps and random back-pressure.
      randomStall = 1'b1;
      for (int n = 0; n < randomCount; n++) begin
         sendInstr(randomInstr());
         if (($random(seed) & 3) == 0) begin
            idleCycles(1 + ($unsigned($random(seed)) % 3));
         end
      end
      waitForDrain();

      $display("Summary: %0d retired, %0d checker errors, %0d flow errors, %0d timeouts, %0d lost",
               retireCount, errorCount, flowErrors, timeouts, pendingCount);
      if (errorCount == 0 && flowErrors == 0 && timeouts == 0 && pendingCount == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
hdl/rvPkg.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/dataMemory.sv
hdl/retireStage.sv
hdl/datapathTop.sv
sim/retireChecker.sv
sim/tbDatapath.sv

// File: Makefile
TOP = tbDatapath

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) | awk '{ print } /^Done: no errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
